//--- rtl/sd_spi_consts.svh
// shared constants for the SPI-mode SD card front end
// one 512-byte sector only, no multi-block support
`ifndef SD_SPI_CONSTS_SVH
`define SD_SPI_CONSTS_SVH

// first command byte, 01 + 6-bit index
`define SD_CMD0          8'h40
`define SD_CMD1          8'h41
`define SD_CMD8          8'h48
`define SD_CMD16         8'h50
`define SD_CMD17         8'h51
`define SD_CMD24         8'h58
`define SD_ACMD41        8'h69
`define SD_CMD55         8'h77
`define SD_CMD58         8'h7A
`define SD_CMD59         8'h7B

`define SD_NCR           4         // fill bytes before R1
`define SD_SECTOR_BYTES  512
`define SD_SECTOR_AW     9

`define SD_TOKEN_START   8'hFE     // data token, both directions
`define SD_DATA_RESP_OK  8'h05     // write accepted
`define SD_R1_IDLE       8'h01
`define SD_R1_READY      8'h00
`define SD_R1_ILLEGAL    8'h04
`define SD_R1_PARAM      8'h40

`endif

//--- rtl/sd_spi_pkg.sv
// types shared by the command controller and the testbench
// opcode values come from the constants header
`default_nettype none

`include "sd_spi_consts.svh"

package sd_spi_pkg;

    typedef enum logic [7:0] {
        OP_CMD0   = `SD_CMD0,   // go idle
        OP_CMD1   = `SD_CMD1,   // send op cond
        OP_CMD8   = `SD_CMD8,   // send if cond
        OP_CMD16  = `SD_CMD16,  // set block length
        OP_CMD17  = `SD_CMD17,  // read single block
        OP_CMD24  = `SD_CMD24,  // write single block
        OP_ACMD41 = `SD_ACMD41, // only after CMD55
        OP_CMD55  = `SD_CMD55,
        OP_CMD58  = `SD_CMD58,  // read OCR
        OP_CMD59  = `SD_CMD59   // crc on/off, ignored
    } sd_opcode_e;

    typedef enum logic [2:0] {
        RD_IDLE, RD_WAIT_HOST, RD_SEND_TOKEN, RD_SEND_DATA
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE, WR_EXPECT_TOKEN, WR_RECV_DATA, WR_RECV_CRC0,
        WR_RECV_CRC1, WR_SEND_RESP, WR_WRITE_HOST, WR_BUSY
    } wr_state_e;

endpackage

`default_nettype wire

//--- rtl/sd_spi_ifs.sv
// internal channels of the card, all in the clk_sys domain
// strobes are single-cycle pulses
`default_nettype none

// byte channel between SPI shifter and command controller
interface spi_byte_if;
    logic [7:0] rx_data;
    logic       rx_strobe;    // byte complete
    logic       tx_take;      // tx_data latched for the next slot
    logic       frame_active; // CS low
    logic [7:0] tx_data;

    modport shifter (output rx_data, rx_strobe, tx_take, frame_active, input tx_data);
    modport ctrl (input rx_data, rx_strobe, tx_take, frame_active, output tx_data);
endinterface

// card side of the sector buffer
interface buf_port_if;
    logic       ptr_clear;
    logic       ptr_step;
    logic       wr_en;
    logic [7:0] wr_data;
    logic [7:0] rd_data;  // byte at pointer, one cycle late
    logic       ptr_last; // pointer at 511

    modport buffer (input ptr_clear, ptr_step, wr_en, wr_data, output rd_data, ptr_last);
    modport ctrl (output ptr_clear, ptr_step, wr_en, wr_data, input rd_data, ptr_last);
endinterface

`default_nettype wire

//--- rtl/spi_byte_shifter.sv
// SPI mode 0 byte framing, MSB first
// pins go through two flops, so SCK half periods need >= 3 clk_sys cycles
// first byte of a frame always goes out as 0xFF
`default_nettype none

module spi_byte_shifter (
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  logic        sck,
    input  logic        cs,
    input  logic        sdi,
    output logic        sdo,
    spi_byte_if.shifter byte_ch
);

    logic [1:0] sck_s;
    logic [1:0] cs_s;
    logic [1:0] sdi_s;
    logic       sck_d;   // previous synced sck
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt;
    logic [7:0] rx_sr;
    logic [7:0] tx_sr;

    assign sck_rise             = sck_s[1] & ~sck_d;
    assign sck_fall             = ~sck_s[1] & sck_d;
    assign byte_ch.frame_active = ~cs_s[1];
    assign byte_ch.rx_data      = rx_sr; // stable until the next rising edge

    always_ff @(posedge clk_sys) begin
        sdi_s <= {sdi_s[0], sdi};
        if (card_is_reset) begin
            sck_s <= 2'b00;
            cs_s  <= 2'b11;    // deselected
            sck_d <= 1'b0;
        end else begin
            sck_s <= {sck_s[0], sck};
            cs_s  <= {cs_s[0], cs};
            sck_d <= sck_s[1];
        end
    end

    always_ff @(posedge clk_sys) begin
        byte_ch.rx_strobe <= 1'b0;
        byte_ch.tx_take   <= 1'b0;
        if (card_is_reset) begin
            bit_cnt <= 3'd0;
            sdo     <= 1'b1;
            tx_sr   <= 8'hFF;
        end else if (cs_s[1]) begin
            bit_cnt <= 3'd0;   // framing restarts on every CS fall
            sdo     <= 1'b1;
            tx_sr   <= 8'hFF;  // idle ones for the first byte
        end else begin
            // card samples on the rising edge
            if (sck_rise) begin
                rx_sr   <= {rx_sr[6:0], sdi_s[1]};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    byte_ch.rx_strobe <= 1'b1;
            end
            // and shifts out on the falling edge
            if (sck_fall) begin
                if (bit_cnt == 3'd0) begin // byte boundary
                    sdo             <= byte_ch.tx_data[7];
                    tx_sr           <= {byte_ch.tx_data[6:0], 1'b1};
                    byte_ch.tx_take <= 1'b1;
                end else begin
                    sdo   <= tx_sr[7];
                    tx_sr <= {tx_sr[6:0], 1'b1};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sector_buffer.sv
// one-sector dual-port RAM, host on port A, card on port B
// port B address is an internal pointer, both reads are registered
// simultaneous writes to one address are not arbitrated
`default_nettype none

`include "sd_spi_consts.svh"

module sector_buffer (
    input  logic                     clk_sys,
    input  logic                     card_is_reset,
    input  logic [`SD_SECTOR_AW-1:0] host_addr,
    input  logic [7:0]               host_wdata,
    input  logic                     host_we,
    output logic [7:0]               host_rdata,
    buf_port_if.buffer               card
);

    logic [7:0]               mem [`SD_SECTOR_BYTES];
    logic [`SD_SECTOR_AW-1:0] ptr;

    assign card.ptr_last = &ptr;

    always_ff @(posedge clk_sys) begin
        if (host_we)
            mem[host_addr] <= host_wdata;
        if (card.wr_en)
            mem[ptr] <= card.wr_data;  // write at pointer, then step
        host_rdata   <= mem[host_addr];
        card.rd_data <= mem[ptr];
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset || card.ptr_clear)
            ptr <= '0;
        else if (card.ptr_step)
            ptr <= ptr + 1'b1;  // wraps after 511
    end

endmodule

`default_nettype wire

//--- rtl/host_request.sv
// sector request handshake toward the IO controller
// a start pulse is dropped while the previous transfer is still busy
// sd_ack is synchronised for the handshake, the buffer write uses it raw
`default_nettype none

module host_request (
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  logic        start_rd,
    input  logic        start_wr,
    input  logic [31:0] arg,
    input  logic        sdhc,
    input  logic        sd_ack,
    input  logic        sd_buff_wr,
    output logic [31:0] sd_lba,
    output logic        sd_rd,
    output logic        sd_wr,
    output logic        sd_busy,
    output logic        buf_write_ok
);

    logic [2:0] ack_s;      // two sync flops + previous
    logic       rd_pending;
    logic       start_ok;
    logic       ack_rise;
    logic       ack_fall;

    assign start_ok     = (start_rd | start_wr) & ~sd_busy;
    assign ack_rise     = ack_s[1] & ~ack_s[2];
    assign ack_fall     = ~ack_s[1] & ack_s[2];
    assign buf_write_ok = sd_buff_wr & sd_ack & rd_pending; // host fills only on reads

    always_ff @(posedge clk_sys) begin
        if (start_ok)
            sd_lba <= sdhc ? arg : {9'd0, arg[31:9]}; // block vs byte address
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            ack_s      <= 3'b000;
            sd_rd      <= 1'b0;
            sd_wr      <= 1'b0;
            sd_busy    <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            ack_s <= {ack_s[1:0], sd_ack};
            if (start_ok) begin
                sd_rd      <= start_rd;
                sd_wr      <= start_wr;
                sd_busy    <= 1'b1;
                rd_pending <= start_rd;
            end else begin
                if (ack_rise) begin    // request seen
                    sd_rd <= 1'b0;
                    sd_wr <= 1'b0;
                end
                if (ack_fall) begin    // transfer done
                    sd_busy    <= 1'b0;
                    rd_pending <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sd_cmd_ctrl.sv
// SD command parser and reply sequencer
// commands are only accepted while no read or write is running
// CS high drops the command, the reply and any transfer in progress
`default_nettype none

`include "sd_spi_consts.svh"

module sd_cmd_ctrl (
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  logic        sdhc,
    spi_byte_if.ctrl    byte_ch,
    buf_port_if.ctrl    buf_ch,
    input  logic        host_busy,
    output logic        start_rd,
    output logic        start_wr,
    output logic [31:0] cmd_arg
);

    import sd_spi_pkg::*;

    sd_opcode_e  cmd;
    rd_state_e   rd_state;
    wr_state_e   wr_state;
    logic [2:0]  cmd_cnt;   // 0 = waiting for a command byte
    logic [31:0] arg;
    logic [7:0]  r1;
    logic [31:0] ext;       // extra reply bytes, sent from the top
    logic        ext_on;
    logic [3:0]  slot;      // byte slots since evaluation, 0 = no reply
    logic        cmd0_seen;
    logic        cmd55;
    logic        rd_req;    // read already passed to the host
    logic        cmd_start;
    logic        eval_now;
    logic [7:0]  r1_n;
    logic [31:0] ext_n;
    logic        ext_on_n;
    logic        go_rd;
    logic        go_wr;
    logic        set55;
    logic [31:0] ocr;

    assign ocr       = {1'b1, sdhc, 6'h0, 9'h1f, 15'h0}; // powered up, 2.7-3.2 V
    assign cmd_arg   = arg;
    assign cmd_start = byte_ch.rx_strobe && cmd_cnt == 3'd0 && byte_ch.rx_data[7:6] == 2'b01
                       && rd_state == RD_IDLE && wr_state == WR_IDLE;
    assign eval_now  = byte_ch.rx_strobe && cmd_cnt == 3'd5; // crc byte in

    // buffer port
    assign buf_ch.ptr_clear = eval_now;
    assign buf_ch.wr_en     = wr_state == WR_RECV_DATA && byte_ch.rx_strobe;
    assign buf_ch.wr_data   = byte_ch.rx_data;
    assign buf_ch.ptr_step  = buf_ch.wr_en || (rd_state == RD_SEND_DATA && byte_ch.tx_take);

    // command decode
    always_comb begin
        r1_n     = `SD_R1_ILLEGAL;
        ext_n    = 32'h0;
        ext_on_n = 1'b0;
        go_rd    = 1'b0;
        go_wr    = 1'b0;
        set55    = 1'b0;
        if (cmd == OP_CMD0) begin
            r1_n = `SD_R1_IDLE;
        end else if (cmd0_seen) begin
            case (cmd)
                OP_CMD1, OP_CMD59: r1_n = `SD_R1_READY;
                OP_CMD8: begin
                    r1_n     = `SD_R1_IDLE;
                    ext_n    = {16'h0, 4'h0, arg[11:8], arg[7:0]}; // voltage + check pattern
                    ext_on_n = 1'b1;
                end
                OP_CMD16: r1_n = (arg == `SD_SECTOR_BYTES) ? `SD_R1_READY : `SD_R1_PARAM;
                OP_CMD17: begin
                    r1_n  = `SD_R1_READY;
                    go_rd = 1'b1;
                end
                OP_CMD24: begin
                    r1_n  = `SD_R1_READY;
                    go_wr = 1'b1;
                end
                OP_CMD55: begin
                    r1_n  = `SD_R1_IDLE;
                    set55 = 1'b1;
                end
                OP_ACMD41: if (cmd55) r1_n = `SD_R1_READY;
                OP_CMD58: begin
                    r1_n     = `SD_R1_READY;
                    ext_n    = ocr;
                    ext_on_n = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // next byte out, transfers override the reply
    always_comb begin
        byte_ch.tx_data = 8'hFF;
        if (rd_state == RD_SEND_TOKEN)
            byte_ch.tx_data = `SD_TOKEN_START;
        else if (rd_state == RD_SEND_DATA)
            byte_ch.tx_data = buf_ch.rd_data;
        else if (wr_state == WR_SEND_RESP)
            byte_ch.tx_data = `SD_DATA_RESP_OK;
        else if (wr_state == WR_WRITE_HOST || wr_state == WR_BUSY)
            byte_ch.tx_data = 8'h00; // busy
        else if (slot == `SD_NCR + 1)
            byte_ch.tx_data = r1;    // after NCR fill bytes
        else if (ext_on && slot > `SD_NCR + 1 && slot <= `SD_NCR + 5)
            byte_ch.tx_data = ext[31:24];
    end

    always_ff @(posedge clk_sys) begin
        if (cmd_start)
            cmd <= sd_opcode_e'(byte_ch.rx_data);
        if (byte_ch.rx_strobe && cmd_cnt != 3'd0 && cmd_cnt != 3'd5)
            arg <= {arg[23:0], byte_ch.rx_data}; // MSB first
        if (eval_now) begin
            r1     <= r1_n;
            ext    <= ext_n;
            ext_on <= ext_on_n;
        end else if (byte_ch.tx_take && slot > `SD_NCR + 1) begin
            ext <= {ext[23:0], 8'hFF};
        end
    end

    always_ff @(posedge clk_sys) begin
        start_rd <= 1'b0;
        start_wr <= 1'b0;
        if (card_is_reset) begin
            cmd_cnt   <= 3'd0;
            slot      <= 4'd0;
            cmd0_seen <= 1'b0;
            cmd55     <= 1'b0;
            rd_req    <= 1'b0;
            rd_state  <= RD_IDLE;
            wr_state  <= WR_IDLE;
        end else if (!byte_ch.frame_active) begin
            cmd_cnt  <= 3'd0;
            slot     <= 4'd0;
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            if (cmd_start) begin
                cmd_cnt <= 3'd1;
                slot    <= 4'd0;
            end else if (byte_ch.rx_strobe && cmd_cnt != 3'd0) begin
                cmd_cnt <= (cmd_cnt == 3'd5) ? 3'd0 : cmd_cnt + 3'd1;
            end

            if (eval_now) begin
                slot      <= 4'd1;  // next take is slot 1
                cmd0_seen <= cmd0_seen | (cmd == OP_CMD0);
                cmd55     <= set55; // any other command clears it
                rd_req    <= 1'b0;
                if (go_rd) rd_state <= RD_WAIT_HOST;
                if (go_wr) wr_state <= WR_EXPECT_TOKEN;
            end else if (byte_ch.tx_take && slot != 4'd0 && slot != 4'hF) begin
                slot <= slot + 4'd1;
            end

            // read, stepped on byte slots so busy has time to rise
            case (rd_state)
                RD_WAIT_HOST: if (byte_ch.tx_take) begin
                    if (!rd_req) begin
                        if (!host_busy) begin
                            start_rd <= 1'b1;
                            rd_req   <= 1'b1;
                        end
                    end else if (!host_busy && slot > `SD_NCR) begin
                        rd_state <= RD_SEND_TOKEN; // sector is in
                    end
                end
                RD_SEND_TOKEN: if (byte_ch.tx_take) rd_state <= RD_SEND_DATA;
                RD_SEND_DATA: if (byte_ch.tx_take && buf_ch.ptr_last) rd_state <= RD_IDLE;
                default: ;
            endcase

            case (wr_state)
                WR_EXPECT_TOKEN:
                    if (byte_ch.rx_strobe && byte_ch.rx_data == `SD_TOKEN_START)
                        wr_state <= WR_RECV_DATA;
                WR_RECV_DATA: if (buf_ch.wr_en && buf_ch.ptr_last) wr_state <= WR_RECV_CRC0;
                WR_RECV_CRC0: if (byte_ch.rx_strobe) wr_state <= WR_RECV_CRC1; // crc ignored
                WR_RECV_CRC1: if (byte_ch.rx_strobe) wr_state <= WR_SEND_RESP;
                WR_SEND_RESP: if (byte_ch.tx_take) wr_state <= WR_WRITE_HOST;
                WR_WRITE_HOST: if (byte_ch.tx_take && !host_busy) begin
                    start_wr <= 1'b1;
                    wr_state <= WR_BUSY;
                end
                WR_BUSY: if (byte_ch.tx_take && !host_busy) wr_state <= WR_IDLE;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/sd_card_spi.sv
// SD card in SPI mode, backed by a host sector request port
// sdhc selects block addressing and the OCR capacity bit
// single-block CMD17/CMD24 only, no CSD/CID
`default_nettype none

`include "sd_spi_consts.svh"

module sd_card_spi (
    input  logic                     clk_sys,
    input  logic                     card_is_reset,
    input  logic                     sdhc,
    input  logic                     sd_sck,
    input  logic                     sd_cs,
    input  logic                     sd_sdi,
    output logic                     sd_sdo,
    output logic [31:0]              sd_lba,
    output logic                     sd_rd,
    output logic                     sd_wr,
    output logic                     sd_busy,
    input  logic                     sd_ack,
    input  logic [`SD_SECTOR_AW-1:0] sd_buff_addr,
    input  logic [7:0]               sd_buff_dout,
    input  logic                     sd_buff_wr,
    output logic [7:0]               sd_buff_din
);

    logic        start_rd;
    logic        start_wr;
    logic [31:0] cmd_arg;
    logic        buf_write_ok;

    spi_byte_if byte_ch ();
    buf_port_if card_buf ();

    spi_byte_shifter u_shifter (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sck           (sd_sck),
        .cs            (sd_cs),
        .sdi           (sd_sdi),
        .sdo           (sd_sdo),
        .byte_ch       (byte_ch.shifter)
    );

    sd_cmd_ctrl u_ctrl (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sdhc          (sdhc),
        .byte_ch       (byte_ch.ctrl),
        .buf_ch        (card_buf.ctrl),
        .host_busy     (sd_busy),
        .start_rd      (start_rd),
        .start_wr      (start_wr),
        .cmd_arg       (cmd_arg)
    );

    sector_buffer u_buffer (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .host_addr     (sd_buff_addr),
        .host_wdata    (sd_buff_dout),
        .host_we       (buf_write_ok),
        .host_rdata    (sd_buff_din),
        .card          (card_buf.buffer)
    );

    host_request u_host (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .start_rd      (start_rd),
        .start_wr      (start_wr),
        .arg           (cmd_arg),
        .sdhc          (sdhc),
        .sd_ack        (sd_ack),
        .sd_buff_wr    (sd_buff_wr),
        .sd_lba        (sd_lba),
        .sd_rd         (sd_rd),
        .sd_wr         (sd_wr),
        .sd_busy       (sd_busy),
        .buf_write_ok  (buf_write_ok)
    );

endmodule

`default_nettype wire

//--- tb/io_ctrl_model.sv
// behavioral IO controller on the host side of the card
// reads fill the buffer with (lba + addr) mod 256, writes are copied out
// one request at a time, every handshake wait is bounded
`default_nettype none

module io_ctrl_model (
    input  logic        clk_sys,
    input  logic [31:0] sd_lba,
    input  logic        sd_rd,
    input  logic        sd_wr,
    input  logic        sd_busy,
    input  logic [7:0]  sd_buff_din,
    output logic        sd_ack,
    output logic [8:0]  sd_buff_addr,
    output logic [7:0]  sd_buff_dout,
    output logic        sd_buff_wr,
    output int          fault_count
);

    logic [7:0] sector_copy [512]; // last written sector

    initial begin
        sd_ack       = 1'b0;
        sd_buff_addr = 9'd0;
        sd_buff_dout = 8'h00;
        sd_buff_wr   = 1'b0;
        fault_count  = 0;
    end

    task automatic step();
        @(posedge clk_sys);
        #1; // sample and drive just after the edge
    endtask

    // drop sd_ack once the request is gone, then see busy fall
    task automatic finish_handshake(input string what);
        int n;
        n = 0;
        while ((sd_rd || sd_wr) && n < 32) begin
            step();
            n++;
        end
        if (sd_rd || sd_wr) begin
            fault_count++;
            $display("host model: %s request still high long after acknowledge", what);
        end
        sd_ack = 1'b0;
        n = 0;
        while (sd_busy && n < 32) begin
            step();
            n++;
        end
        if (sd_busy) begin
            fault_count++;
            $display("host model: sd_busy did not fall after the %s acknowledge", what);
        end
    endtask

    task automatic serve_read();
        logic [31:0] lba;
        lba    = sd_lba;
        sd_ack = 1'b1;
        for (int i = 0; i < 512; i++) begin
            sd_buff_addr = i[8:0];
            sd_buff_dout = lba[7:0] + i[7:0]; // wraps mod 256
            sd_buff_wr   = 1'b1;
            step();
        end
        sd_buff_wr = 1'b0;
        finish_handshake("read");
    endtask

    task automatic serve_write();
        sd_ack = 1'b1;
        for (int i = 0; i < 512; i++) begin
            sd_buff_addr = i[8:0];
            step();
            sector_copy[i] = sd_buff_din; // registered read, one cycle
        end
        finish_handshake("write");
    endtask

    always @(posedge clk_sys) begin
        #1;
        if (sd_rd)
            serve_read();
        else if (sd_wr)
            serve_write();
    end

endmodule

`default_nettype wire

//--- tb/tb_sd_card_spi.sv
// testbench for the SPI-mode SD card behind a behavioral IO controller
// SPI mode 0, 4 clk_sys cycles per SCK half period, CS toggled per command
// CRC bytes are dummies, the card ignores them
`default_nettype none

module tb_sd_card_spi;

    import sd_spi_pkg::*;

    localparam int SECTOR = 512;

    logic        clk_sys;
    logic        card_is_reset;
    logic        sdhc;
    logic        sd_sck;
    logic        sd_cs;
    logic        sd_sdi;
    logic        sd_sdo;
    logic [31:0] sd_lba;
    logic        sd_rd;
    logic        sd_wr;
    logic        sd_busy;
    logic        sd_ack;
    logic [8:0]  sd_buff_addr;
    logic [7:0]  sd_buff_dout;
    logic        sd_buff_wr;
    logic [7:0]  sd_buff_din;
    int          checks;
    int          mismatches;
    int          timeouts;
    int          host_faults;
    logic [31:0] rng;
    logic [7:0]  sent_data [SECTOR]; // last sector written over SPI

    sd_card_spi DUT (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sdhc          (sdhc),
        .sd_sck        (sd_sck),
        .sd_cs         (sd_cs),
        .sd_sdi        (sd_sdi),
        .sd_sdo        (sd_sdo),
        .sd_lba        (sd_lba),
        .sd_rd         (sd_rd),
        .sd_wr         (sd_wr),
        .sd_busy       (sd_busy),
        .sd_ack        (sd_ack),
        .sd_buff_addr  (sd_buff_addr),
        .sd_buff_dout  (sd_buff_dout),
        .sd_buff_wr    (sd_buff_wr),
        .sd_buff_din   (sd_buff_din)
    );

    io_ctrl_model host_model (
        .clk_sys      (clk_sys),
        .sd_lba       (sd_lba),
        .sd_rd        (sd_rd),
        .sd_wr        (sd_wr),
        .sd_busy      (sd_busy),
        .sd_buff_din  (sd_buff_din),
        .sd_ack       (sd_ack),
        .sd_buff_addr (sd_buff_addr),
        .sd_buff_dout (sd_buff_dout),
        .sd_buff_wr   (sd_buff_wr),
        .fault_count  (host_faults)
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] next_random(); // xorshift32
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #2; // drive point, clear of the edge
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // one byte, MSB first, sdo sampled at the rising SCK edge
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            sd_sdi = tx[b];     // changes with the falling edge
            wait_cycles(4);
            sd_sck = 1'b1;
            rx[b]  = sd_sdo;
            wait_cycles(4);
            sd_sck = 1'b0;
        end
    endtask

    task automatic scan_reply(input string name, output logic [7:0] r1);
        int         n;
        logic [7:0] b;
        b = 8'hFF;
        n = 0;
        while (b === 8'hFF && n < 8) begin
            spi_xfer(8'hFF, b);
            n++;
        end
        if (b === 8'hFF) begin
            timeouts++;
            $display("timeout: no R1 reply to %s within 8 byte slots", name);
        end
        r1 = b;
    endtask

    task automatic wait_token(input string name, output logic found);
        int         n;
        logic [7:0] b;
        b = 8'hFF;
        n = 0;
        while (b !== 8'hFE && n < 4000) begin
            spi_xfer(8'hFF, b);
            n++;
        end
        found = (b === 8'hFE);
        if (!found) begin
            timeouts++;
            $display("timeout: no start token for %s within 4000 byte slots", name);
        end
    endtask

    // CS low, six command bytes, then the R1 check, frame left open
    task automatic issue_command(input string name, input logic [7:0] op,
                                 input logic [31:0] arg, input logic [7:0] exp_r1);
        logic [7:0] rx;
        logic [7:0] r1;
        sd_cs = 1'b0;
        wait_cycles(4);
        spi_xfer(op, rx);
        spi_xfer(arg[31:24], rx);
        spi_xfer(arg[23:16], rx);
        spi_xfer(arg[15:8], rx);
        spi_xfer(arg[7:0], rx);
        spi_xfer(8'h95, rx);    // dummy crc, end bit set
        scan_reply(name, r1);
        check_value(name, exp_r1, r1);
    endtask

    task automatic end_frame();
        wait_cycles(4);         // last SCK fall reaches the card first
        sd_cs = 1'b1;
        wait_cycles(8);
    endtask

    task automatic read_word(output logic [31:0] w);
        logic [7:0] b;
        for (int i = 0; i < 4; i++) begin
            spi_xfer(8'hFF, b);
            w = {w[23:0], b};   // MSB first
        end
    endtask

    task automatic read_block(input string name, input logic use_sdhc);
        logic [31:0] arg;
        logic [31:0] lba;
        logic [7:0]  b;
        logic        found;
        sdhc = use_sdhc;
        arg  = next_random();
        lba  = use_sdhc ? arg : arg >> 9; // block vs byte address
        issue_command(name, OP_CMD17, arg, 8'h00);
        wait_token(name, found);
        if (found) begin
            for (int i = 0; i < SECTOR; i++) begin
                spi_xfer(8'hFF, b);
                check_value({name, " data"}, (lba + i) & 32'hFF, b);
            end
        end
        end_frame();
        check_value({name, " lba"}, lba, sd_lba);
    endtask

    task automatic write_block(input string name, input logic use_sdhc);
        logic [31:0] arg;
        logic [31:0] lba;
        logic [7:0]  b;
        int          n;
        sdhc = use_sdhc;
        arg  = next_random();
        lba  = use_sdhc ? arg : arg >> 9;
        issue_command(name, OP_CMD24, arg, 8'h00);
        spi_xfer(8'hFE, b);
        for (int i = 0; i < SECTOR; i++) begin
            sent_data[i] = next_random() & 32'hFF;
            spi_xfer(sent_data[i], b);
        end
        spi_xfer(8'hA5, b);     // crc, ignored
        spi_xfer(8'h5A, b);
        spi_xfer(8'hFF, b);
        check_value({name, " data response"}, 8'h05, b);
        spi_xfer(8'hFF, b);
        check_value({name, " first busy byte"}, 8'h00, b);
        n = 0;
        while (b === 8'h00 && n < 4000) begin
            spi_xfer(8'hFF, b);
            n++;
        end
        if (b === 8'h00) begin
            timeouts++;
            $display("timeout: card still busy after 4000 byte slots in %s", name);
        end else begin
            check_value({name, " end of busy"}, 8'hFF, b);
        end
        end_frame();
        check_value({name, " lba"}, lba, sd_lba);
        for (int i = 0; i < SECTOR; i++)
            check_value({name, " host copy"}, sent_data[i], host_model.sector_copy[i]);
    endtask

    initial begin
        logic [31:0] arg;
        logic [31:0] word;
        sd_cs         = 1'b1;
        sd_sck        = 1'b0;
        sd_sdi        = 1'b1;
        sdhc          = 1'b0;
        card_is_reset = 1'b1;
        checks        = 0;
        mismatches    = 0;
        timeouts      = 0;
        rng           = 32'h92fc_d6b7;
        wait_cycles(10);
        card_is_reset = 1'b0;
        wait_cycles(4);

        // reset values and command ordering
        check_value("reset sd_rd", 1'b0, sd_rd);
        check_value("reset sd_wr", 1'b0, sd_wr);
        check_value("reset sd_busy", 1'b0, sd_busy);
        check_value("reset sd_sdo", 1'b1, sd_sdo);
        issue_command("cmd17 before cmd0", OP_CMD17, 32'h0, 8'h04);
        end_frame();
        check_value("no read before cmd0", 1'b0, sd_rd | sd_busy);
        issue_command("cmd0", OP_CMD0, 32'h0, 8'h01);
        end_frame();

        // init sequence
        arg = next_random();
        issue_command("cmd8", OP_CMD8, arg, 8'h01);
        read_word(word);
        end_frame();
        check_value("cmd8 echo", {20'h0, arg[11:8], arg[7:0]}, word);
        issue_command("cmd55", OP_CMD55, 32'h0, 8'h01);
        end_frame();
        issue_command("acmd41", OP_ACMD41, 32'h4000_0000, 8'h00);
        end_frame();
        issue_command("cmd59", OP_CMD59, 32'h0, 8'h00);
        end_frame();
        issue_command("cmd16 512", OP_CMD16, 32'd512, 8'h00);
        end_frame();
        issue_command("cmd16 odd length", OP_CMD16, next_random() | 32'h1, 8'h40);
        end_frame();

        // OCR, capacity bit follows sdhc
        sdhc = 1'b1;
        issue_command("cmd58 sdhc", OP_CMD58, 32'h0, 8'h00);
        read_word(word);
        end_frame();
        check_value("ocr sdhc", 32'hC00F_8000, word);
        sdhc = 1'b0;
        issue_command("cmd58 sdsc", OP_CMD58, 32'h0, 8'h00);
        read_word(word);
        end_frame();
        check_value("ocr sdsc", 32'h800F_8000, word);

        read_block("read byte addr", 1'b0);
        read_block("read block addr", 1'b1);
        write_block("write byte addr", 1'b0);
        write_block("write block addr", 1'b1);

        $display("checks %0d, mismatches %0d, timeouts %0d, host model faults %0d",
                 checks, mismatches, timeouts, host_faults);
        if (mismatches == 0 && timeouts == 0 && host_faults == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/sd_spi_pkg.sv
rtl/sd_spi_ifs.sv
rtl/spi_byte_shifter.sv
rtl/sector_buffer.sv
rtl/host_request.sv
rtl/sd_cmd_ctrl.sv
rtl/sd_card_spi.sv
tb/io_ctrl_model.sv
tb/tb_sd_card_spi.sv
